//--- verilog/index_gen_pkg.sv
package index_gen_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int INDEX_WIDTH = 32;
    localparam int SHIFT_WIDTH = 5;

    // ------------------------------
    // Request FIFO sizing
    // ------------------------------
    localparam int FIFO_DEPTH       = 16;
    localparam int FIFO_ADDR_WIDTH  = 4;
    // Fill level where the sequencer backs off
    localparam int FIFO_PROG_THRESH = 8;

    // Index, stride, end, offset and base all share this width
    typedef logic [INDEX_WIDTH-1:0] index_t;

    typedef logic [SHIFT_WIDTH-1:0] shift_amount_t;

    // One extra bit so a full FIFO is distinct from an empty one
    typedef logic [FIFO_ADDR_WIDTH:0] fifo_count_t;

    // Sequencer states
    typedef enum logic [3:0] {
        RESET       = 4'd0,
        IDLE        = 4'd1,
        SETUP       = 4'd2,
        START       = 4'd3,
        BUSY        = 4'd4,
        PAUSE_TRANS = 4'd5,
        PAUSE       = 4'd6,
        BUSY_TRANS  = 4'd7,
        DONE        = 4'd8
    } gen_state_t;

endpackage : index_gen_pkg

//--- verilog/index_config_latch.sv
module index_config_latch (
    input  logic                         ap_clk,
    input  logic                         areset_generator,
    input  logic                         configure_valid,
    input  index_gen_pkg::index_t        configure_index_start,
    input  index_gen_pkg::index_t        configure_index_end,
    input  index_gen_pkg::index_t        configure_stride,
    input  logic                         configure_shift_left,
    input  index_gen_pkg::shift_amount_t configure_shift_amount,
    input  logic                         idle,
    output logic                         start,
    output index_gen_pkg::index_t        cfg_index_start,
    output index_gen_pkg::index_t        cfg_index_end,
    output index_gen_pkg::index_t        cfg_stride,
    output logic                         cfg_shift_left,
    output index_gen_pkg::shift_amount_t cfg_shift_amount
);

    logic accept;

    // Sequencer still sits in IDLE during the start cycle, so block a second strobe there
    assign accept = configure_valid & idle & ~start;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            start <= 1'b0;
        end else begin
            start <= accept;
        end
    end

    // Fields held for the whole run
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            cfg_index_start  <= configure_index_start;
            cfg_index_end    <= configure_index_end;
            cfg_stride       <= configure_stride;
            cfg_shift_left   <= configure_shift_left;
            cfg_shift_amount <= configure_shift_amount;
        end
    end

endmodule : index_config_latch

//--- verilog/index_counter.sv
module index_counter (
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  logic                  load,
    input  logic                  step,
    input  index_gen_pkg::index_t load_value,
    input  index_gen_pkg::index_t stride,
    output index_gen_pkg::index_t count
);

    index_gen_pkg::index_t count_next;

    // Load wins over step
    always_comb begin
        count_next = count;
        if (load) begin
            count_next = load_value;
        end else if (step) begin
            count_next = count + stride;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

endmodule : index_counter

//--- verilog/index_sequencer.sv
module index_sequencer (
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  logic                  start,
    input  logic                  prog_full,
    input  index_gen_pkg::index_t count,
    input  index_gen_pkg::index_t cfg_index_end,
    output logic                  counter_load,
    output logic                  counter_step,
    output logic                  emit_valid,
    output logic                  idle,
    output logic                  done
);

    index_gen_pkg::gen_state_t current_state;
    index_gen_pkg::gen_state_t next_state;

    logic below_end;

    // Upward count only, so the run ends once count reaches or passes end
    assign below_end = count < cfg_index_end;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            current_state <= index_gen_pkg::RESET;
        end else begin
            current_state <= next_state;
        end
    end

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        next_state = current_state;
        case (current_state)
            index_gen_pkg::RESET: next_state = index_gen_pkg::IDLE;
            index_gen_pkg::IDLE: begin
                if (start) begin
                    next_state = index_gen_pkg::SETUP;
                end
            end
            index_gen_pkg::SETUP: next_state = index_gen_pkg::START;
            index_gen_pkg::START: next_state = index_gen_pkg::BUSY;
            index_gen_pkg::BUSY: begin
                if (!below_end) begin
                    next_state = index_gen_pkg::DONE;
                end else if (prog_full) begin
                    next_state = index_gen_pkg::PAUSE_TRANS;
                end
            end
            index_gen_pkg::PAUSE_TRANS: next_state = index_gen_pkg::PAUSE;
            index_gen_pkg::PAUSE: begin
                if (!prog_full) begin
                    next_state = index_gen_pkg::BUSY_TRANS;
                end
            end
            index_gen_pkg::BUSY_TRANS: next_state = index_gen_pkg::BUSY;
            index_gen_pkg::DONE: next_state = index_gen_pkg::IDLE;
            default: next_state = index_gen_pkg::RESET;
        endcase
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign counter_load = current_state == index_gen_pkg::SETUP;

    // One index per BUSY cycle, the step moves to the next one
    assign emit_valid   = (current_state == index_gen_pkg::BUSY) & below_end;
    assign counter_step = emit_valid;

    assign idle = current_state == index_gen_pkg::IDLE;

    // Registered, so done lags the state by one edge
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            done <= 1'b0;
        end else begin
            done <= (current_state == index_gen_pkg::IDLE) |
                    (current_state == index_gen_pkg::DONE);
        end
    end

endmodule : index_sequencer

//--- verilog/address_formatter.sv
module address_formatter (
    input  logic                         ap_clk,
    input  logic                         areset_generator,
    input  logic                         emit_valid,
    input  index_gen_pkg::index_t        count,
    input  index_gen_pkg::index_t        cfg_index_start,
    input  logic                         cfg_shift_left,
    input  index_gen_pkg::shift_amount_t cfg_shift_amount,
    output logic                         push,
    output index_gen_pkg::index_t        push_index,
    output index_gen_pkg::index_t        push_offset,
    output index_gen_pkg::index_t        push_base
);

    index_gen_pkg::index_t offset_comb;

    // Shift direction picked per run
    always_comb begin
        if (cfg_shift_left) begin
            offset_comb = count << cfg_shift_amount;
        end else begin
            offset_comb = count >> cfg_shift_amount;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            push <= 1'b0;
        end else begin
            push <= emit_valid;
        end
    end

    // Request words
    always_ff @(posedge ap_clk) begin
        push_index  <= count;
        push_offset <= offset_comb;
        push_base   <= cfg_index_start;
    end

endmodule : address_formatter

//--- verilog/request_fifo.sv
module request_fifo (
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  logic                  push,
    input  index_gen_pkg::index_t push_index,
    input  index_gen_pkg::index_t push_offset,
    input  index_gen_pkg::index_t push_base,
    input  logic                  request_ready,
    output logic                  prog_full,
    output logic                  request_valid,
    output index_gen_pkg::index_t request_index,
    output index_gen_pkg::index_t request_offset,
    output index_gen_pkg::index_t request_base
);

    index_gen_pkg::index_t mem_index  [index_gen_pkg::FIFO_DEPTH];
    index_gen_pkg::index_t mem_offset [index_gen_pkg::FIFO_DEPTH];
    index_gen_pkg::index_t mem_base   [index_gen_pkg::FIFO_DEPTH];

    logic [index_gen_pkg::FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [index_gen_pkg::FIFO_ADDR_WIDTH-1:0] rd_ptr;
    index_gen_pkg::fifo_count_t                fill_level;

    logic empty;
    logic full;
    logic wr_en;
    logic pop;

    assign empty     = fill_level == '0;
    assign full      = fill_level == index_gen_pkg::FIFO_DEPTH;
    assign prog_full = fill_level >= index_gen_pkg::FIFO_PROG_THRESH;
    assign wr_en     = push & ~full;
    assign pop       = ~empty & request_ready;

    // ------------------------------
    // Pointers and fill level
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fill_level    <= '0;
            request_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   fill_level <= fill_level + 1'b1;
                2'b01:   fill_level <= fill_level - 1'b1;
                default: fill_level <= fill_level;
            endcase
            request_valid <= pop;
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem_index[wr_ptr]  <= push_index;
            mem_offset[wr_ptr] <= push_offset;
            mem_base[wr_ptr]   <= push_base;
        end
        if (pop) begin
            request_index  <= mem_index[rd_ptr];
            request_offset <= mem_offset[rd_ptr];
            request_base   <= mem_base[rd_ptr];
        end
    end

endmodule : request_fifo

//--- verilog/index_generator_top.sv
module index_generator_top (
    input  logic                         ap_clk,
    input  logic                         areset_generator,
    input  logic                         configure_valid,
    input  index_gen_pkg::index_t        configure_index_start,
    input  index_gen_pkg::index_t        configure_index_end,
    input  index_gen_pkg::index_t        configure_stride,
    input  logic                         configure_shift_left,
    input  index_gen_pkg::shift_amount_t configure_shift_amount,
    input  logic                         request_ready,
    output logic                         request_valid,
    output index_gen_pkg::index_t        request_index,
    output index_gen_pkg::index_t        request_offset,
    output index_gen_pkg::index_t        request_base,
    output logic                         done
);

    // ------------------------------
    // Stage wiring
    // ------------------------------
    logic                         start;
    logic                         idle;
    index_gen_pkg::index_t        cfg_index_start;
    index_gen_pkg::index_t        cfg_index_end;
    index_gen_pkg::index_t        cfg_stride;
    logic                         cfg_shift_left;
    index_gen_pkg::shift_amount_t cfg_shift_amount;

    logic                  counter_load;
    logic                  counter_step;
    logic                  emit_valid;
    index_gen_pkg::index_t count;

    logic                  push;
    index_gen_pkg::index_t push_index;
    index_gen_pkg::index_t push_offset;
    index_gen_pkg::index_t push_base;
    logic                  prog_full;

    index_config_latch u_config (
        .ap_clk                 (ap_clk),
        .areset_generator       (areset_generator),
        .configure_valid        (configure_valid),
        .configure_index_start  (configure_index_start),
        .configure_index_end    (configure_index_end),
        .configure_stride       (configure_stride),
        .configure_shift_left   (configure_shift_left),
        .configure_shift_amount (configure_shift_amount),
        .idle                   (idle),
        .start                  (start),
        .cfg_index_start        (cfg_index_start),
        .cfg_index_end          (cfg_index_end),
        .cfg_stride             (cfg_stride),
        .cfg_shift_left         (cfg_shift_left),
        .cfg_shift_amount       (cfg_shift_amount)
    );

    index_counter u_counter (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .load             (counter_load),
        .step             (counter_step),
        .load_value       (cfg_index_start),
        .stride           (cfg_stride),
        .count            (count)
    );

    index_sequencer u_sequencer (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .prog_full        (prog_full),
        .count            (count),
        .cfg_index_end    (cfg_index_end),
        .counter_load     (counter_load),
        .counter_step     (counter_step),
        .emit_valid       (emit_valid),
        .idle             (idle),
        .done             (done)
    );

    address_formatter u_formatter (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .emit_valid       (emit_valid),
        .count            (count),
        .cfg_index_start  (cfg_index_start),
        .cfg_shift_left   (cfg_shift_left),
        .cfg_shift_amount (cfg_shift_amount),
        .push             (push),
        .push_index       (push_index),
        .push_offset      (push_offset),
        .push_base        (push_base)
    );

    request_fifo u_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (push),
        .push_index       (push_index),
        .push_offset      (push_offset),
        .push_base        (push_base),
        .request_ready    (request_ready),
        .prog_full        (prog_full),
        .request_valid    (request_valid),
        .request_index    (request_index),
        .request_offset   (request_offset),
        .request_base     (request_base)
    );

endmodule : index_generator_top

//--- test/index_generator_assert.sv
module index_generator_assert (
    input logic                       ap_clk,
    input logic                       areset_generator,
    input logic                       push,
    input logic                       request_ready,
    input logic                       request_valid,
    input logic                       empty,
    input index_gen_pkg::fifo_count_t fill_level
);
    timeunit 1ns;
    timeprecision 1ps;

    // Synchronous reset clears the read valid one edge in
    reset_clears_valid: assert property (
        @(posedge ap_clk) $past(areset_generator) |-> !request_valid
    ) else $error("request_valid high right after a reset cycle");

    // A push into a full FIFO would drop a request
    no_push_when_full: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        !(push && fill_level == index_gen_pkg::fifo_count_t'(index_gen_pkg::FIFO_DEPTH))
    ) else $error("push while the request FIFO is full");

    // Read valid only follows a real pop
    valid_follows_pop: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        request_valid |-> $past(request_ready && !empty)
    ) else $error("request_valid without a pop in the previous cycle");

endmodule : index_generator_assert

bind request_fifo index_generator_assert u_fifo_assert (
    .ap_clk           (ap_clk),
    .areset_generator (areset_generator),
    .push             (push),
    .request_ready    (request_ready),
    .request_valid    (request_valid),
    .empty            (empty),
    .fill_level       (fill_level)
);

//--- test/index_generator_tb.sv
module index_generator_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 3000;

    logic                         ap_clk;
    logic                         areset_generator;
    logic                         configure_valid;
    index_gen_pkg::index_t        configure_index_start;
    index_gen_pkg::index_t        configure_index_end;
    index_gen_pkg::index_t        configure_stride;
    logic                         configure_shift_left;
    index_gen_pkg::shift_amount_t configure_shift_amount;
    logic                         request_ready;
    logic                         request_valid;
    index_gen_pkg::index_t        request_index;
    index_gen_pkg::index_t        request_offset;
    index_gen_pkg::index_t        request_base;
    logic                         done;

    // Expected requests in arrival order
    index_gen_pkg::index_t exp_index[$];
    index_gen_pkg::index_t exp_offset[$];
    index_gen_pkg::index_t exp_base[$];

    string                        test_name;
    int                           received;
    int                           expected_total;
    int                           first_received;
    int                           run_count;
    index_gen_pkg::index_t        last_index;
    logic [31:0]                  lfsr_state;
    logic [31:0]                  ready_bits;
    logic                         random_ready;
    index_gen_pkg::index_t        rand_start;
    index_gen_pkg::index_t        rand_end;
    index_gen_pkg::index_t        rand_stride;
    logic [31:0]                  rand_word;

    index_generator_top UUT (
        .ap_clk                 (ap_clk),
        .areset_generator       (areset_generator),
        .configure_valid        (configure_valid),
        .configure_index_start  (configure_index_start),
        .configure_index_end    (configure_index_end),
        .configure_stride       (configure_stride),
        .configure_shift_left   (configure_shift_left),
        .configure_shift_amount (configure_shift_amount),
        .request_ready          (request_ready),
        .request_valid          (request_valid),
        .request_index          (request_index),
        .request_offset         (request_offset),
        .request_base           (request_base),
        .done                   (done)
    );

    always #50 ap_clk = ~ap_clk;

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Reference model of one run, returns the number of requests
    function automatic int build_expected(
        input index_gen_pkg::index_t        start_index,
        input index_gen_pkg::index_t        end_index,
        input index_gen_pkg::index_t        stride,
        input logic                         shift_left,
        input index_gen_pkg::shift_amount_t amount
    );
        index_gen_pkg::index_t idx;
        int                    n;
        idx = start_index;
        n = 0;
        while (idx < end_index) begin
            exp_index.push_back(idx);
            if (shift_left) begin
                exp_offset.push_back(idx << amount);
            end else begin
                exp_offset.push_back(idx >> amount);
            end
            exp_base.push_back(start_index);
            idx = idx + stride;
            n++;
        end
        return n;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_field(
        input string                 field,
        input index_gen_pkg::index_t expected,
        input index_gen_pkg::index_t actual
    );
        assert (actual == expected) else begin
            report_failure($sformatf("FAILED %s %s expected %0d actual %0d",
                                     test_name, field, expected, actual));
        end
    endtask

    task automatic wait_for_done(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (done !== level && cycles < WAIT_LIMIT) begin
            @(posedge ap_clk);
            cycles++;
        end
        assert (done === level) else begin
            report_failure($sformatf("Timed out waiting for %s in %s", what, test_name));
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_index.size() != 0 && cycles < WAIT_LIMIT) begin
            @(posedge ap_clk);
            cycles++;
        end
        assert (exp_index.size() == 0) else begin
            report_failure($sformatf("Timed out waiting for %0d requests in %s",
                                     exp_index.size(), test_name));
        end
    endtask

    // Configure one run and wait until done comes back
    task automatic run_config(
        input index_gen_pkg::index_t        start_index,
        input index_gen_pkg::index_t        end_index,
        input index_gen_pkg::index_t        stride,
        input logic                         shift_left,
        input index_gen_pkg::shift_amount_t amount,
        input logic                         stray
    );
        wait_for_done(1'b1, "done before configuration");
        run_count = build_expected(start_index, end_index, stride, shift_left, amount);
        expected_total += run_count;
        @(posedge ap_clk);
        configure_valid        <= 1'b1;
        configure_index_start  <= start_index;
        configure_index_end    <= end_index;
        configure_stride       <= stride;
        configure_shift_left   <= shift_left;
        configure_shift_amount <= amount;
        @(posedge ap_clk);
        configure_valid <= 1'b0;
        wait_for_done(1'b0, "done to fall");
        if (stray) begin
            // Must be ignored, the run is already going
            @(posedge ap_clk);
            configure_valid       <= 1'b1;
            configure_index_start <= 32'd0;
            configure_index_end   <= 32'd1000;
            @(posedge ap_clk);
            configure_valid <= 1'b0;
        end
        wait_for_done(1'b1, "done to rise");
    endtask

    // ------------------------------
    // Ready driver and comparison
    // ------------------------------
    always @(posedge ap_clk) begin
        if (random_ready) begin
            ready_bits = take_bits(1);
            request_ready <= ready_bits[0];
        end else begin
            request_ready <= 1'b1;
        end
    end

    always @(posedge ap_clk) begin
        if (!areset_generator && request_valid) begin
            assert (exp_index.size() > 0) else begin
                report_failure($sformatf("Unexpected request with index %0d in %s",
                                         request_index, test_name));
            end
            if (exp_index.size() > 0) begin
                check_field("index", exp_index.pop_front(), request_index);
                check_field("offset", exp_offset.pop_front(), request_offset);
                check_field("base", exp_base.pop_front(), request_base);
                received++;
                last_index = request_index;
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        ap_clk                 = 1'b0;
        areset_generator       = 1'b1;
        configure_valid        = 1'b0;
        configure_index_start  = '0;
        configure_index_end    = '0;
        configure_stride       = '0;
        configure_shift_left   = 1'b0;
        configure_shift_amount = '0;
        request_ready          = 1'b0;
        random_ready           = 1'b0;
        lfsr_state             = 32'h068d7507;
        received               = 0;
        expected_total         = 0;
        last_index             = '0;
        test_name              = "reset";

        repeat (3) @(posedge ap_clk);
        areset_generator <= 1'b0;
        wait_for_done(1'b1, "done after reset");

        test_name = "stride_one_left";
        run_config(32'd5, 32'd40, 32'd1, 1'b1, 5'd3, 1'b0);
        wait_drain();

        // 14 indices from 3 up to 94, the next one would pass the end
        test_name = "stride_seven_right";
        first_received = received;
        run_config(32'd3, 32'd100, 32'd7, 1'b0, 5'd2, 1'b0);
        wait_drain();
        assert (received - first_received == 14) else begin
            report_failure($sformatf("FAILED %s count expected %0d actual %0d",
                                     test_name, 14, received - first_received));
        end
        assert (last_index == 32'd94) else begin
            report_failure($sformatf("FAILED %s last index expected %0d actual %0d",
                                     test_name, 94, last_index));
        end

        // Configuration drawn before the ready driver starts using the LFSR
        test_name   = "random_ready";
        rand_start  = take_bits(6);
        rand_stride = take_bits(2) + 32'd1;
        rand_end    = rand_start + 32'd200 + take_bits(5);
        rand_word   = take_bits(4);
        @(posedge ap_clk);
        random_ready <= 1'b1;
        run_config(rand_start, rand_end, rand_stride, rand_word[3],
                   {2'b00, rand_word[2:0]}, 1'b0);
        wait_drain();
        @(posedge ap_clk);
        random_ready <= 1'b0;

        test_name = "empty_range";
        run_config(32'd60, 32'd50, 32'd1, 1'b1, 5'd1, 1'b0);
        wait_drain();

        test_name = "back_to_back";
        run_config(32'd10, 32'd30, 32'd2, 1'b1, 5'd4, 1'b0);
        run_config(32'd100, 32'd140, 32'd3, 1'b0, 5'd1, 1'b1);
        wait_drain();

        if (exp_index.size() == 0 && received == expected_total) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : index_generator_tb

//--- build.f
verilog/index_gen_pkg.sv
verilog/index_config_latch.sv
verilog/index_counter.sv
verilog/index_sequencer.sv
verilog/address_formatter.sv
verilog/request_fifo.sv
verilog/index_generator_top.sv
test/index_generator_assert.sv
test/index_generator_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module index_generator_tb -o index_generator_sim \
    && ./obj_dir/index_generator_sim > sim.log 2>&1 \
    || { echo "Build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0
